/* Makefile */
TOP := tb_fb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* fb_apply_ctrl.sv */
module fb_apply_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 apply,
    input  fb_pkg::apply_flags_t apply_flags,
    input  logic                 color_done,
    input  logic                 depth_done,
    input  logic                 fb_swapped,
    output logic                 color_start,
    output logic                 depth_start,
    output logic                 swap_fb,
    output logic                 cmd_ready
);

    fb_pkg::apply_state_t state;
    logic                 color_pend;
    logic                 depth_pend;
    logic                 swap_req;
    logic                 clears_done;

    // A pending clear is finished in the cycle its done arrives
    assign clears_done = (!color_pend || color_done) && (!depth_pend || depth_done);

    assign swap_fb   = (state == fb_pkg::SWAP);
    assign cmd_ready = (state == fb_pkg::IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= fb_pkg::IDLE;
            color_pend  <= 1'b0;
            depth_pend  <= 1'b0;
            swap_req    <= 1'b0;
            color_start <= 1'b0;
            depth_start <= 1'b0;
        end
        else
        begin
            color_start <= 1'b0;
            depth_start <= 1'b0;

            case (state)
                fb_pkg::IDLE:
                begin
                    if (apply)
                    begin
                        // Starts go out in the first CLEAR cycle
                        color_pend  <= apply_flags.memset_color;
                        depth_pend  <= apply_flags.memset_depth;
                        swap_req    <= apply_flags.swap;
                        color_start <= apply_flags.memset_color;
                        depth_start <= apply_flags.memset_depth;
                        state       <= fb_pkg::CLEAR;
                    end
                end
                fb_pkg::CLEAR:
                begin
                    if (color_done)
                    begin
                        color_pend <= 1'b0;
                    end
                    if (depth_done)
                    begin
                        depth_pend <= 1'b0;
                    end
                    if (clears_done)
                    begin
                        state <= swap_req ? fb_pkg::SWAP : fb_pkg::IDLE;
                    end
                end
                fb_pkg::SWAP:
                begin
                    state <= fb_pkg::WAIT_SWAPPED;
                end
                fb_pkg::WAIT_SWAPPED:
                begin
                    // Display side acknowledges with a level
                    if (fb_swapped)
                    begin
                        state <= fb_pkg::IDLE;
                    end
                end
                default:
                begin
                    state <= fb_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* fb_cmd_regs.sv */
module fb_cmd_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  logic                 cmd_ready,
    input  fb_pkg::cmd_word_t    cmd_data,
    output fb_pkg::buf_conf_t    color_conf,
    output fb_pkg::buf_conf_t    depth_conf,
    output fb_pkg::screen_pos_t  res_x,
    output fb_pkg::screen_pos_t  res_y,
    output logic                 apply,
    output fb_pkg::apply_flags_t apply_flags
);

    logic                 accept;
    fb_pkg::cmd_op_t      op;
    fb_pkg::cmd_payload_t payload;

    assign accept  = cmd_valid && cmd_ready;
    assign op      = fb_pkg::cmd_op_t'(cmd_data[fb_pkg::CMD_WIDTH-1 -: fb_pkg::CMD_OP_WIDTH]);
    assign payload = cmd_data[fb_pkg::CMD_PAYLOAD_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            color_conf  <= '0;
            depth_conf  <= '0;
            res_x       <= '0;
            res_y       <= '0;
            apply       <= 1'b0;
            apply_flags <= '0;
        end
        else
        begin
            // One cycle pulse towards the sequencer
            apply <= accept && (op == fb_pkg::OP_APPLY);

            if (accept)
            begin
                case (op)
                    fb_pkg::OP_CLEAR_COLOR:
                    begin
                        color_conf.clear <=
                            fb_pkg::to_rgb565(payload[fb_pkg::RGB888_WIDTH-1:0]);
                    end
                    fb_pkg::OP_CLEAR_DEPTH:
                    begin
                        depth_conf.clear <= payload[fb_pkg::PIXEL_WIDTH-1:0];
                    end
                    fb_pkg::OP_COLOR_ADDR:
                    begin
                        color_conf.base <= payload[fb_pkg::FB_INDEX_WIDTH-1:0];
                    end
                    fb_pkg::OP_DEPTH_ADDR:
                    begin
                        depth_conf.base <= payload[fb_pkg::FB_INDEX_WIDTH-1:0];
                    end
                    fb_pkg::OP_RESOLUTION:
                    begin
                        // x in the low field, y right above it
                        res_x <= payload[fb_pkg::SCREEN_POS_WIDTH-1:0];
                        res_y <= payload[2*fb_pkg::SCREEN_POS_WIDTH-1 -: fb_pkg::SCREEN_POS_WIDTH];
                    end
                    fb_pkg::OP_APPLY:
                    begin
                        apply_flags <= payload[$bits(fb_pkg::apply_flags_t)-1:0];
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

/* fb_memset.sv */
module fb_memset (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  fb_pkg::buf_conf_t   conf,
    input  fb_pkg::screen_pos_t res_x,
    input  fb_pkg::screen_pos_t res_y,
    input  logic                wready,
    output fb_pkg::fb_wr_t      wr,
    output logic                done
);

    fb_pkg::pixel_count_t pixel_count;
    fb_pkg::pixel_count_t last_pixel;
    fb_pkg::pixel_count_t pixel_cnt;
    fb_pkg::buf_conf_t    conf_q;
    logic                 busy;

    assign pixel_count = fb_pkg::pixel_count_t'(res_x) * fb_pkg::pixel_count_t'(res_y);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy      <= 1'b0;
            done      <= 1'b0;
            pixel_cnt <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                pixel_cnt <= '0;
                busy      <= (pixel_count != '0);
                // Empty region finishes right away
                done      <= (pixel_count == '0);
            end
            else if (busy && wready)
            begin
                if (pixel_cnt == last_pixel)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            conf_q     <= conf;
            last_pixel <= pixel_count - 1'b1;
        end
    end

    // All fields come from registers, so a stalled write stays put
    assign wr.valid = busy;
    assign wr.addr  = conf_q.base + pixel_cnt[fb_pkg::FB_INDEX_WIDTH-1:0];
    assign wr.data  = conf_q.clear;

endmodule

/* fb_pkg.sv */
package fb_pkg;

    localparam int CMD_WIDTH         = 32;
    localparam int CMD_OP_WIDTH      = 4;
    localparam int CMD_PAYLOAD_WIDTH = 28;
    localparam int FB_INDEX_WIDTH    = 20;
    localparam int SCREEN_POS_WIDTH  = 11;
    localparam int PIXEL_WIDTH       = 16;
    localparam int RGB888_WIDTH      = 24;
    localparam int PIXEL_COUNT_WIDTH = 2 * SCREEN_POS_WIDTH;

    typedef logic [CMD_WIDTH-1:0]         cmd_word_t;
    typedef logic [CMD_PAYLOAD_WIDTH-1:0] cmd_payload_t;
    typedef logic [FB_INDEX_WIDTH-1:0]    fb_index_t;
    typedef logic [SCREEN_POS_WIDTH-1:0]  screen_pos_t;
    typedef logic [PIXEL_WIDTH-1:0]       fb_word_t;
    typedef logic [RGB888_WIDTH-1:0]      rgb888_t;
    typedef logic [PIXEL_COUNT_WIDTH-1:0] pixel_count_t;

    // Opcode sits in the top nibble of a command word
    typedef enum logic [CMD_OP_WIDTH-1:0] {
        OP_NOP         = 4'd0,
        OP_CLEAR_COLOR = 4'd1,
        OP_CLEAR_DEPTH = 4'd2,
        OP_COLOR_ADDR  = 4'd3,
        OP_DEPTH_ADDR  = 4'd4,
        OP_RESOLUTION  = 4'd5,
        OP_APPLY       = 4'd6
    } cmd_op_t;

    // Low payload bits of OP_APPLY
    typedef struct packed {
        logic memset_color;
        logic memset_depth;
        logic swap;
    } apply_flags_t;

    typedef struct packed {
        logic      valid;
        fb_index_t addr;
        fb_word_t  data;
    } fb_wr_t;

    typedef struct packed {
        fb_index_t base;
        fb_word_t  clear;
    } buf_conf_t;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        SWAP,
        WAIT_SWAPPED
    } apply_state_t;

    // Keep the upper bits of each channel
    function automatic fb_word_t to_rgb565(input rgb888_t color);
        return {color[23:19], color[15:10], color[7:3]};
    endfunction

endpackage

/* fb_top.sv */
module fb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  fb_pkg::cmd_word_t cmd_data,
    output fb_pkg::fb_wr_t    color_wr,
    input  logic              color_wready,
    output fb_pkg::fb_wr_t    depth_wr,
    input  logic              depth_wready,
    output logic              swap_fb,
    output fb_pkg::fb_index_t fb_addr,
    input  logic              fb_swapped
);

    fb_pkg::buf_conf_t    color_conf;
    fb_pkg::buf_conf_t    depth_conf;
    fb_pkg::screen_pos_t  res_x;
    fb_pkg::screen_pos_t  res_y;
    logic                 apply;
    fb_pkg::apply_flags_t apply_flags;
    logic                 color_start;
    logic                 depth_start;
    logic                 color_done;
    logic                 depth_done;

    // Display scans out the color buffer
    assign fb_addr = color_conf.base;

    fb_cmd_regs cmd_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .color_conf  (color_conf),
        .depth_conf  (depth_conf),
        .res_x       (res_x),
        .res_y       (res_y),
        .apply       (apply),
        .apply_flags (apply_flags)
    );

    fb_apply_ctrl apply_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .apply       (apply),
        .apply_flags (apply_flags),
        .color_done  (color_done),
        .depth_done  (depth_done),
        .fb_swapped  (fb_swapped),
        .color_start (color_start),
        .depth_start (depth_start),
        .swap_fb     (swap_fb),
        .cmd_ready   (cmd_ready)
    );

    fb_memset color_clear (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (color_start),
        .conf   (color_conf),
        .res_x  (res_x),
        .res_y  (res_y),
        .wready (color_wready),
        .wr     (color_wr),
        .done   (color_done)
    );

    fb_memset depth_clear (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (depth_start),
        .conf   (depth_conf),
        .res_x  (res_x),
        .res_y  (res_y),
        .wready (depth_wready),
        .wr     (depth_wr),
        .done   (depth_done)
    );

endmodule

/* fb_top_props.sv */
module fb_top_props (
    input logic           clk,
    input logic           rst_n,
    input logic           cmd_ready,
    input fb_pkg::fb_wr_t color_wr,
    input logic           color_wready,
    input fb_pkg::fb_wr_t depth_wr,
    input logic           depth_wready,
    input logic           swap_fb
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled write holds valid, addr and data
    color_hold: assert property (@(posedge clk) disable iff (!rst_n)
        color_wr.valid && !color_wready |=> $stable(color_wr))
        else $error("color write port changed while stalled");

    depth_hold: assert property (@(posedge clk) disable iff (!rst_n)
        depth_wr.valid && !depth_wready |=> $stable(depth_wr))
        else $error("depth write port changed while stalled");

    swap_single: assert property (@(posedge clk) disable iff (!rst_n)
        swap_fb |=> !swap_fb)
        else $error("swap_fb high for two cycles");

    swap_busy: assert property (@(posedge clk) disable iff (!rst_n)
        swap_fb |-> !cmd_ready)
        else $error("cmd_ready high while swap_fb is high");

    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !swap_fb && !color_wr.valid && !depth_wr.valid)
        else $error("swap or write active right after reset");

endmodule

bind fb_top fb_top_props props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .color_wr     (color_wr),
    .color_wready (color_wready),
    .depth_wr     (depth_wr),
    .depth_wready (depth_wready),
    .swap_fb      (swap_fb)
);

/* sources.f */
fb_pkg.sv
fb_cmd_regs.sv
fb_apply_ctrl.sv
fb_memset.sv
fb_top.sv
fb_top_props.sv
tb_fb_top.sv

/* tb_fb_top.sv */
module tb_fb_top;

    timeunit 1ns;
    timeprecision 1ps;

    // Pixels over all tests with the combined clear counted once per buffer
    localparam int TEST_PIXELS     = 15 + 24 + 2 * 12;
    localparam int MAX_SWAP_WAIT   = 4;
    localparam int WATCHDOG_CYCLES = (TEST_PIXELS + 2 * MAX_SWAP_WAIT) * 4 + 1000;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cmd_valid;
    logic              cmd_ready;
    fb_pkg::cmd_word_t cmd_data;
    fb_pkg::fb_wr_t    color_wr;
    fb_pkg::fb_wr_t    depth_wr;
    logic              color_wready = 1'b1;
    logic              depth_wready = 1'b1;
    logic              swap_fb;
    fb_pkg::fb_index_t fb_addr;
    logic              fb_swapped;

    // Model of the configuration the tests have sent
    fb_pkg::fb_index_t exp_color_base = '0;
    fb_pkg::fb_index_t exp_depth_base = '0;
    fb_pkg::fb_word_t  exp_color = '0;
    fb_pkg::fb_word_t  exp_depth = '0;
    int                pixels = 0;
    int                exp_color_writes = 0;
    int                exp_depth_writes = 0;
    int                color_cnt = 0;
    int                depth_cnt = 0;
    int                swap_cnt = 0;
    int                mon_errors = 0;
    int                seq_errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    string             test_name = "reset";
    logic              stall_en = 1'b0;
    logic              color_stalled = 1'b0;
    logic              depth_stalled = 1'b0;
    fb_pkg::fb_wr_t    color_held;
    fb_pkg::fb_wr_t    depth_held;
    logic [31:0]       stall_rng = 32'hb960_3238;
    logic [31:0]       value_rng = 32'hb960_3238;

    fb_top fb_top_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic show_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic show_error(input string what);
        $display("ERROR %s: %s", test_name, what);
    endtask

    // Random write stalls while a test asks for them
    always @(posedge clk)
    begin
        stall_rng = lcg_next(stall_rng);
        color_wready <= stall_en ? stall_rng[27] : 1'b1;
        depth_wready <= stall_en ? stall_rng[29] : 1'b1;
    end

    // Checks every accepted write and every swap request
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (cmd_valid && cmd_ready && cmd_data[31:28] == fb_pkg::OP_APPLY)
            begin
                color_cnt = 0;
                depth_cnt = 0;
                swap_cnt  = 0;
            end
            assert (!(color_stalled && color_wr != color_held)
                    && !(depth_stalled && depth_wr != depth_held))
            else
            begin
                show_error("a stalled write port changed before its write was taken");
                mon_errors++;
            end
            if (color_wr.valid && color_wready)
            begin
                assert (color_wr.addr == exp_color_base + 20'(color_cnt)
                        && color_wr.data == exp_color)
                else
                begin
                    show_mismatch("color write", {exp_color_base + 20'(color_cnt), exp_color},
                                  {color_wr.addr, color_wr.data});
                    mon_errors++;
                end
                color_cnt++;
            end
            if (depth_wr.valid && depth_wready)
            begin
                assert (depth_wr.addr == exp_depth_base + 20'(depth_cnt)
                        && depth_wr.data == exp_depth)
                else
                begin
                    show_mismatch("depth write", {exp_depth_base + 20'(depth_cnt), exp_depth},
                                  {depth_wr.addr, depth_wr.data});
                    mon_errors++;
                end
                depth_cnt++;
            end
            if (swap_fb)
            begin
                swap_cnt++;
                assert (fb_addr == exp_color_base)
                else
                begin
                    show_mismatch("fb_addr", 64'(exp_color_base), 64'(fb_addr));
                    mon_errors++;
                end
                assert (!cmd_ready && color_cnt == exp_color_writes
                        && depth_cnt == exp_depth_writes)
                else
                begin
                    show_error("swap_fb came with cmd_ready high or before the clears ended");
                    mon_errors++;
                end
            end
            color_stalled = color_wr.valid && !color_wready;
            depth_stalled = depth_wr.valid && !depth_wready;
            color_held    = color_wr;
            depth_held    = depth_wr;
        end
    end

    task automatic send_cmd(input fb_pkg::cmd_op_t op, input logic [27:0] payload);
        cmd_valid <= 1'b1;
        cmd_data  <= {op, payload};
        do
            @(posedge clk);
        while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic configure(input fb_pkg::fb_index_t color_base,
                             input fb_pkg::fb_index_t depth_base, input int x, input int y);
        fb_pkg::rgb888_t rgb;
        value_rng = lcg_next(value_rng);
        rgb       = value_rng[31:8];
        value_rng = lcg_next(value_rng);
        exp_color_base = color_base;
        exp_depth_base = depth_base;
        // RGB565 keeps the top 5, 6 and 5 bits of red, green and blue
        exp_color = {5'(rgb[23:16] >> 3), 6'(rgb[15:8] >> 2), 5'(rgb[7:0] >> 3)};
        exp_depth = value_rng[31:16];
        pixels    = x * y;
        send_cmd(fb_pkg::OP_COLOR_ADDR, 28'(color_base));
        send_cmd(fb_pkg::OP_DEPTH_ADDR, 28'(depth_base));
        send_cmd(fb_pkg::OP_CLEAR_COLOR, 28'(rgb));
        send_cmd(fb_pkg::OP_CLEAR_DEPTH, 28'(exp_depth));
        send_cmd(fb_pkg::OP_RESOLUTION, {6'd0, 11'(y), 11'(x)});
    endtask

    task automatic end_test(input int start_errors);
        int new_errors;
        new_errors = mon_errors + seq_errors - start_errors;
        tests_run++;
        if (new_errors == 0)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, new_errors);
        end
    endtask

    // Flag bits are memset_color, memset_depth, swap from the top
    task automatic run_apply(input string name, input fb_pkg::apply_flags_t flags,
                             input logic stall);
        int start_errors;
        int hold;
        test_name        = name;
        start_errors     = mon_errors + seq_errors;
        exp_color_writes = flags.memset_color ? pixels : 0;
        exp_depth_writes = flags.memset_depth ? pixels : 0;
        stall_en <= stall;
        send_cmd(fb_pkg::OP_APPLY, {25'd0, flags});
        while (cmd_ready)
            @(posedge clk);
        if (flags.swap)
        begin
            while (!swap_fb)
                @(posedge clk);
            value_rng = lcg_next(value_rng);
            hold      = 1 + int'(value_rng[31:30]);
            repeat (hold)
            begin
                @(posedge clk);
                assert (!cmd_ready)
                else
                begin
                    show_error("cmd_ready rose before fb_swapped");
                    seq_errors++;
                end
            end
            fb_swapped <= 1'b1;
        end
        while (!cmd_ready)
            @(posedge clk);
        fb_swapped <= 1'b0;
        stall_en   <= 1'b0;
        assert (color_cnt == exp_color_writes && depth_cnt == exp_depth_writes
                && swap_cnt == int'(flags.swap))
        else
        begin
            show_mismatch("color, depth and swap counts",
                          {16'(exp_color_writes), 16'(exp_depth_writes), 16'(flags.swap)},
                          {16'(color_cnt), 16'(depth_cnt), 16'(swap_cnt)});
            seq_errors++;
        end
        end_test(start_errors);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_data   = '0;
        fb_swapped = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_name = "reset_values";
        assert (cmd_ready && !swap_fb && !color_wr.valid && !depth_wr.valid)
        else
        begin
            show_error("outputs are not at their reset values");
            seq_errors++;
        end
        end_test(0);
        configure(20'h0_1000, 20'h4_0000, 5, 3);
        run_apply("color_clear", 3'b100, 1'b0);
        configure(20'h0_1000, 20'h4_0200, 6, 4);
        run_apply("depth_clear_stalled", 3'b010, 1'b1);
        configure(20'h2_0000, 20'h6_0100, 4, 3);
        run_apply("clear_both_and_swap", 3'b111, 1'b1);
        run_apply("swap_only", 3'b001, 1'b0);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 mon_errors + seq_errors);
        if (mon_errors + seq_errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
